/* logic/darb_pkg.sv */
package darb_pkg;

    ////////////////////////////////////////
    // CPU port window
    ////////////////////////////////////////

    // Port numbers seen on sfc_dcu_port
    // Ports 7, 8 and 11 are not decoded and read back as zero
    typedef enum logic [3:0] {
        PORT_READ     = 4'h0,
        PORT_BASE0    = 4'h1,
        PORT_BASE1    = 4'h2,
        PORT_BASE2    = 4'h3,
        PORT_INDEX    = 4'h4,
        PORT_OFFSET0  = 4'h5,
        PORT_OFFSET1  = 4'h6,
        PORT_COUNTER0 = 4'h9,
        PORT_COUNTER1 = 4'hA,
        PORT_STATUS   = 4'hC
    } darb_port_e;

    // STATUS value while the input ring holds data
    localparam logic [7:0] STATUS_READY = 8'h80;

    ////////////////////////////////////////
    // Fetch engine
    ////////////////////////////////////////

    // Lookup reads three directory bytes, then streams ROM data
    typedef enum logic [1:0] {
        IDLE,
        ADDR_READ,
        STREAM
    } fetch_state_e;

    localparam int ROM_ADDR_W      = 24;
    localparam int PSRAM_ADDR_W    = 23;
    localparam int DIR_ENTRY_BYTES = 4;

    // Cycles an access must hold without a CPU ROM read
    localparam int PSRAM_TIMING = 7;
    localparam int PSRAM_CTR_W  = $clog2(PSRAM_TIMING + 1);

    // Input ring, one slot kept free to tell full from empty
    localparam int RING_AW    = 10;
    localparam int RING_DEPTH = 1 << RING_AW;

endpackage

/* logic/darb_port_ctrl.sv */
`timescale 1ns/1ps

module darb_port_ctrl (
    input  logic                            CLK,
    input  logic                            rst_n,
    input  darb_pkg::darb_port_e            sfc_dcu_port,
    input  logic                            sfc_dcu_rd,
    input  logic                            sfc_dcu_wr,
    input  logic [7:0]                      sfc_data_in,
    output logic [7:0]                      sfc_data_out,
    output logic                            start,
    output logic [darb_pkg::ROM_ADDR_W-1:0] dir_ptr,
    darb_ring_if.port                       ring
);
    import darb_pkg::*;

    // CPU register file
    logic [ROM_ADDR_W-1:0] dir_base;
    logic [7:0]            dir_index;
    // Offset is kept for readback and as the start trigger
    logic [15:0]           offset_reg;
    logic [15:0]           length_ctr;
    logic                  read_pop;

    // READ strobe consumes the head byte when there is one
    assign read_pop = sfc_dcu_rd && (sfc_dcu_port == PORT_READ) && !ring.empty;
    assign ring.pop = read_pop;

    ////////////////////////////////////////
    // Port writes
    ////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            dir_base   <= '0;
            dir_index  <= '0;
            offset_reg <= '0;
            length_ctr <= '0;
            dir_ptr    <= '0;
            start      <= 1'b0;
        end else begin
            start <= 1'b0;
            if (sfc_dcu_wr) begin
                case (sfc_dcu_port)
                    PORT_BASE0:    dir_base[7:0]    <= sfc_data_in;
                    PORT_BASE1:    dir_base[15:8]   <= sfc_data_in;
                    PORT_BASE2:    dir_base[23:16]  <= sfc_data_in;
                    PORT_INDEX:    dir_index        <= sfc_data_in;
                    PORT_OFFSET0:  offset_reg[7:0]  <= sfc_data_in;
                    PORT_OFFSET1: begin
                        offset_reg[15:8] <= sfc_data_in;
                        // Address bytes sit one past the mode byte of the entry
                        dir_ptr <= ROM_ADDR_W'(dir_base + dir_index * DIR_ENTRY_BYTES + 1);
                        start   <= 1'b1;
                    end
                    PORT_COUNTER0: length_ctr[7:0]  <= sfc_data_in;
                    PORT_COUNTER1: length_ctr[15:8] <= sfc_data_in;
                    default: ;
                endcase
            end else if (read_pop) begin
                length_ctr <= length_ctr - 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Port reads
    ////////////////////////////////////////

    // Read data holds until the next read strobe
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            sfc_data_out <= 8'h00;
        end else if (sfc_dcu_rd) begin
            case (sfc_dcu_port)
                PORT_READ:     sfc_data_out <= ring.empty ? 8'h00 : ring.pop_data;
                PORT_BASE0:    sfc_data_out <= dir_base[7:0];
                PORT_BASE1:    sfc_data_out <= dir_base[15:8];
                PORT_BASE2:    sfc_data_out <= dir_base[23:16];
                PORT_INDEX:    sfc_data_out <= dir_index;
                PORT_OFFSET0:  sfc_data_out <= offset_reg[7:0];
                PORT_OFFSET1:  sfc_data_out <= offset_reg[15:8];
                PORT_COUNTER0: sfc_data_out <= length_ctr[7:0];
                PORT_COUNTER1: sfc_data_out <= length_ctr[15:8];
                // Ready as soon as one byte is buffered
                PORT_STATUS:   sfc_data_out <= ring.empty ? 8'h00 : STATUS_READY;
                default:       sfc_data_out <= 8'h00;
            endcase
        end
    end

    // CPU bus carries one access at a time
    a_rd_wr_excl : assert property (@(posedge CLK) disable iff (!rst_n)
        !(sfc_dcu_rd && sfc_dcu_wr))
        else $error("port read and write in the same cycle");

endmodule

/* logic/darb_ring_buffer.sv */
`timescale 1ns/1ps

module darb_ring_buffer (
    input  logic      CLK,
    input  logic      rst_n,
    darb_ring_if.ring ring
);
    import darb_pkg::*;

    // Input ring storage
    logic [7:0]         mem [RING_DEPTH];
    // Next slot to write
    logic [RING_AW-1:0] wr_ptr;
    // Next slot to read
    logic [RING_AW-1:0] rd_ptr;

    ////////////////////////////////////////
    // Flags and read port
    ////////////////////////////////////////

    // Head byte is always visible to the port controller
    assign ring.pop_data = mem[rd_ptr];
    assign ring.empty    = (wr_ptr == rd_ptr);
    // Full one slot early, so 1023 bytes at most
    assign ring.full     = (RING_AW'(wr_ptr + 1'b1) == rd_ptr);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (ring.flush) begin
            // Flush beats any push or pop in the same cycle
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (ring.push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (ring.pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage write
    always_ff @(posedge CLK) begin
        if (ring.push && !ring.flush) begin
            mem[wr_ptr] <= ring.push_data;
        end
    end

    // Fetch engine holds off on a full ring
    a_no_push_full : assert property (@(posedge CLK) disable iff (!rst_n)
        !(ring.push && ring.full && !ring.flush))
        else $error("push into a full ring");

    // Port controller only pops when data is there
    a_no_pop_empty : assert property (@(posedge CLK) disable iff (!rst_n)
        !(ring.pop && ring.empty && !ring.flush))
        else $error("pop from an empty ring");

endmodule

/* logic/darb_ring_if.sv */
`timescale 1ns/1ps

interface darb_ring_if;

    // Producer side
    logic       push;
    logic [7:0] push_data;
    logic       flush;

    // Consumer side
    logic       pop;
    logic [7:0] pop_data;

    // Fill flags from the ring pointers
    logic       empty;
    logic       full;

    modport fetch (output push, push_data, flush, input full);

    modport ring (input push, push_data, flush, pop, output pop_data, empty, full);

    modport port (output pop, input pop_data, empty);

endinterface

/* logic/darb_rom_fetch.sv */
`timescale 1ns/1ps

module darb_rom_fetch (
    input  logic                              CLK,
    input  logic                              rst_n,
    input  logic                              start,
    input  logic [darb_pkg::ROM_ADDR_W-1:0]   dir_ptr,
    input  logic                              sfc_rom_rd,
    input  logic [15:0]                       psram_data,
    output logic [darb_pkg::PSRAM_ADDR_W-1:0] psram_addr,
    output logic                              darb_rom_rd,
    darb_ring_if.fetch                        ring
);
    import darb_pkg::*;

    fetch_state_e           state;
    // Directory bytes taken so far
    logic [1:0]             dir_cnt;
    // Remaining unpre-empted cycles of the current access
    logic [PSRAM_CTR_W-1:0] wait_ctr;
    // Byte address of the next access
    logic [ROM_ADDR_W-1:0]  rd_addr;
    // Upper two bytes of the data ROM address, high byte first
    logic [15:0]            dir_data;
    logic [7:0]             rd_byte;
    logic                   access_go;
    logic                   access_done;

    ////////////////////////////////////////
    // Access control
    ////////////////////////////////////////

    // Even byte on the high lane, odd byte on the low lane
    assign rd_byte = rd_addr[0] ? psram_data[7:0] : psram_data[15:8];

    // Launch only from an idle bus
    // Streaming also waits for room in the ring
    assign access_go = !darb_rom_rd &&
                       ((state == ADDR_READ) || ((state == STREAM) && !ring.full));

    // Last counted cycle with no CPU read in it
    assign access_done = darb_rom_rd && !sfc_rom_rd && (wait_ctr == PSRAM_CTR_W'(1));

    // A start empties the ring at the same edge it restarts the lookup
    assign ring.flush     = start;
    assign ring.push      = access_done && (state == STREAM) && !start;
    assign ring.push_data = rd_byte;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state       <= IDLE;
            darb_rom_rd <= 1'b0;
            wait_ctr    <= '0;
            dir_cnt     <= '0;
        end else if (start) begin
            // Abort whatever access is in flight
            state       <= ADDR_READ;
            darb_rom_rd <= 1'b0;
            wait_ctr    <= '0;
            dir_cnt     <= '0;
        end else if (access_go) begin
            darb_rom_rd <= 1'b1;
            wait_ctr    <= PSRAM_CTR_W'(PSRAM_TIMING);
        end else if (darb_rom_rd) begin
            if (sfc_rom_rd) begin
                // CPU took the bus so count the full time again
                wait_ctr <= PSRAM_CTR_W'(PSRAM_TIMING);
            end else if (access_done) begin
                darb_rom_rd <= 1'b0;
                wait_ctr    <= '0;
                if (state == ADDR_READ) begin
                    dir_cnt <= dir_cnt + 1'b1;
                    // Third directory byte completes the address
                    if (dir_cnt == 2'd2) begin
                        state <= STREAM;
                    end
                end
            end else begin
                wait_ctr <= wait_ctr - 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Address datapath
    ////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (start) begin
            rd_addr <= dir_ptr;
        end else if (access_go) begin
            // Word address held for the whole access
            psram_addr <= rd_addr[ROM_ADDR_W-1:1];
        end else if (access_done) begin
            if (state == ADDR_READ) begin
                dir_data <= {dir_data[7:0], rd_byte};
                // Jump to the data ROM once all three bytes are in
                if (dir_cnt == 2'd2) begin
                    rd_addr <= {dir_data, rd_byte};
                end else begin
                    rd_addr <= rd_addr + 1'b1;
                end
            end else begin
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    // PSRAM sees the word of the byte in flight until the access ends
    a_addr_held : assert property (@(posedge CLK) disable iff (!rst_n)
        darb_rom_rd |-> (psram_addr == rd_addr[ROM_ADDR_W-1:1]))
        else $error("psram_addr left the word of the byte in flight");

endmodule

/* logic/spc7110_darb.sv */
`timescale 1ns/1ps

module spc7110_darb (
    input  logic                              CLK,
    input  logic                              rst_n,
    // CPU side
    input  logic                              sfc_rom_rd,
    input  logic [3:0]                        sfc_dcu_port,
    input  logic                              sfc_dcu_rd,
    input  logic                              sfc_dcu_wr,
    input  logic [7:0]                        sfc_data_in,
    output logic [7:0]                        sfc_data_out,
    // PSRAM side
    input  logic [15:0]                       psram_data,
    output logic [darb_pkg::PSRAM_ADDR_W-1:0] psram_addr,
    output logic                              darb_rom_rd
);
    import darb_pkg::*;

    // Lookup request from the port registers
    logic                  start;
    logic [ROM_ADDR_W-1:0] dir_ptr;

    darb_ring_if ring_bus ();

    // Directory lookup and PSRAM streaming
    darb_rom_fetch u_fetch (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .start       (start),
        .dir_ptr     (dir_ptr),
        .sfc_rom_rd  (sfc_rom_rd),
        .psram_data  (psram_data),
        .psram_addr  (psram_addr),
        .darb_rom_rd (darb_rom_rd),
        .ring        (ring_bus.fetch)
    );

    darb_ring_buffer u_ring (
        .CLK   (CLK),
        .rst_n (rst_n),
        .ring  (ring_bus.ring)
    );

    // CPU register window
    darb_port_ctrl u_port (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .sfc_dcu_port (darb_port_e'(sfc_dcu_port)),
        .sfc_dcu_rd   (sfc_dcu_rd),
        .sfc_dcu_wr   (sfc_dcu_wr),
        .sfc_data_in  (sfc_data_in),
        .sfc_data_out (sfc_data_out),
        .start        (start),
        .dir_ptr      (dir_ptr),
        .ring         (ring_bus.port)
    );

endmodule

/* spc7110_darb.f */
logic/darb_pkg.sv
logic/darb_ring_if.sv
logic/darb_rom_fetch.sv
logic/darb_ring_buffer.sv
logic/darb_port_ctrl.sv
logic/spc7110_darb.sv
tb/darb_psram_model.sv
tb/darb_tb.sv

/* tb/darb_psram_model.sv */
`timescale 1ns/1ps

module darb_psram_model (
    input  logic                              sfc_rom_rd,
    input  logic [darb_pkg::PSRAM_ADDR_W-1:0] psram_addr,
    output logic [15:0]                       psram_data
);

    // 64 KB window of the data ROM, byte addressed
    logic [7:0]  image [65536];
    // Even byte of the addressed word
    logic [15:0] even_addr;

    assign even_addr = {psram_addr[14:0], 1'b0};

    ////////////////////////////////////////
    // Bus presentation
    ////////////////////////////////////////

    // Even byte on the high lane, odd byte on the low lane
    // A CPU ROM read owns the bus, so the fetch engine sees junk
    assign psram_data = sfc_rom_rd ? 16'hDEAD
                                   : {image[even_addr], image[even_addr | 16'h0001]};

endmodule

/* tb/darb_tb.sv */
`timescale 1ns/1ps

module darb_tb;
    import darb_pkg::*;

    localparam int          POLL_LIMIT = 400;
    localparam logic [23:0] DIR_BASE   = 24'h000100;
    localparam logic [23:0] ROM_ADDR_A = 24'h002345;
    localparam logic [23:0] ROM_ADDR_B = 24'h008123;
    localparam logic [15:0] LENGTH     = 16'h0123;

    logic        CLK;
    logic        rst_n;
    logic        sfc_rom_rd;
    logic [3:0]  sfc_dcu_port;
    logic        sfc_dcu_rd;
    logic        sfc_dcu_wr;
    logic [7:0]  sfc_data_in;
    logic [7:0]  sfc_data_out;
    logic [15:0] psram_data;
    logic [22:0] psram_addr;
    logic        darb_rom_rd;
    // LCG state shared by the image fill and the ROM read noise
    logic [31:0] lcg_state;
    logic [31:0] noise_word;
    logic        rom_noise;
    // READ pops so far for the expected length counter
    int          n_read;

    spc7110_darb dut0 (.*);

    darb_psram_model psram0 (
        .sfc_rom_rd (sfc_rom_rd),
        .psram_addr (psram_addr),
        .psram_data (psram_data)
    );

    always #5 CLK = ~CLK;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Expected stream byte straight from the ROM image
    function automatic logic [7:0] image_byte(input logic [23:0] addr);
        return psram0.image[addr[15:0]];
    endfunction

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp)
        else begin
            $display("ERROR at %0t: %s read %02h, expected %02h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic write_port(input darb_port_e port, input logic [7:0] value);
        @(posedge CLK);
        sfc_dcu_port <= port;
        sfc_data_in  <= value;
        sfc_dcu_wr   <= 1'b1;
        @(posedge CLK);
        sfc_dcu_wr   <= 1'b0;
    endtask

    // Data lands at the sampling edge and is picked up half a cycle later
    task automatic read_port(input darb_port_e port, output logic [7:0] value);
        @(posedge CLK);
        sfc_dcu_port <= port;
        sfc_dcu_rd   <= 1'b1;
        @(posedge CLK);
        sfc_dcu_rd   <= 1'b0;
        @(negedge CLK);
        value = sfc_data_out;
    endtask

    task automatic write_and_check(input darb_port_e port, input logic [7:0] value);
        logic [7:0] got;
        write_port(port, value);
        read_port(port, got);
        check_value(port.name(), got, value);
    endtask

    // Address bytes follow the mode byte of entry base + 4*index
    task automatic load_entry(input logic [7:0] index, input logic [23:0] rom_addr);
        logic [15:0] entry;
        entry = 16'(DIR_BASE + index * DIR_ENTRY_BYTES + 1);
        psram0.image[entry]         = rom_addr[23:16];
        psram0.image[entry + 16'd1] = rom_addr[15:8];
        psram0.image[entry + 16'd2] = rom_addr[7:0];
    endtask

    task automatic wait_ready();
        logic [7:0] status;
        int         polls;
        status = 8'h00;
        polls  = 0;
        while (status != STATUS_READY && polls < POLL_LIMIT) begin
            read_port(PORT_STATUS, status);
            polls++;
        end
        if (status != STATUS_READY) begin
            $display("Timed out waiting for STATUS to show buffered data");
            abort_run();
        end
    endtask

    task automatic read_stream(input logic [23:0] base, input int first, input int count);
        logic [7:0] got;
        for (int i = 0; i < count; i++) begin
            wait_ready();
            read_port(PORT_READ, got);
            check_value("READ", got, image_byte(24'(base + first + i)));
            n_read++;
        end
    endtask

    task automatic check_counter();
        logic [15:0] exp;
        logic [7:0]  got;
        exp = LENGTH - 16'(n_read);
        read_port(PORT_COUNTER0, got);
        check_value("COUNTER0", got, exp[7:0]);
        read_port(PORT_COUNTER1, got);
        check_value("COUNTER1", got, exp[15:8]);
    endtask

    ////////////////////////////////////////
    // Checks on the PSRAM side
    ////////////////////////////////////////

    // One word address per access even when pre-empted
    addr_held : assert property (@(posedge CLK) disable iff (!rst_n)
        darb_rom_rd |=> (!darb_rom_rd || $stable(psram_addr)))
        else begin
            $display("ERROR at %0t: psram_addr changed during a PSRAM access", $time);
            abort_run();
        end

    reset_quiet : assert property (@(posedge CLK)
        !rst_n |=> (!darb_rom_rd && sfc_data_out == 8'h00))
        else begin
            $display("ERROR at %0t: outputs not idle after reset", $time);
            abort_run();
        end

    // Sparse CPU ROM reads pre-empt the fetch engine
    always @(posedge CLK) begin
        if (rom_noise) begin
            noise_word = next_rand();
            sfc_rom_rd <= (noise_word[27:25] == 3'd0);
        end else begin
            sfc_rom_rd <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        logic [31:0] word;
        logic [7:0]  value;
        CLK          = 1'b0;
        rst_n        = 1'b0;
        sfc_rom_rd   = 1'b0;
        sfc_dcu_port = 4'h0;
        sfc_dcu_rd   = 1'b0;
        sfc_dcu_wr   = 1'b0;
        sfc_data_in  = 8'h00;
        rom_noise    = 1'b0;
        n_read       = 0;
        lcg_state    = 32'd12;
        // ROM image mixes the LCG with both address bytes
        for (int a = 0; a < 65536; a++) begin
            word = next_rand();
            psram0.image[a] = word[31:24] ^ 8'(a) ^ 8'(a >> 8);
        end
        load_entry(8'd3, ROM_ADDR_A);
        load_entry(8'd5, ROM_ADDR_B);
        repeat (4) @(posedge CLK);
        rst_n <= 1'b1;

        // Idle state and register readback
        read_port(PORT_STATUS, value);
        check_value("STATUS after reset", value, 8'h00);
        check_value("darb_rom_rd after reset", {7'd0, darb_rom_rd}, 8'h00);
        write_and_check(PORT_BASE0, DIR_BASE[7:0]);
        write_and_check(PORT_BASE1, DIR_BASE[15:8]);
        write_and_check(PORT_BASE2, DIR_BASE[23:16]);
        write_and_check(PORT_INDEX, 8'd3);
        write_and_check(PORT_OFFSET0, 8'h5A);
        write_and_check(PORT_COUNTER0, LENGTH[7:0]);
        write_and_check(PORT_COUNTER1, LENGTH[15:8]);
        // Offset high byte kicks off the lookup
        write_and_check(PORT_OFFSET1, 8'hC3);

        // Quiet bus stream followed by the length counter
        read_stream(ROM_ADDR_A, 0, 40);
        check_counter();

        // Same stream under CPU pre-emption
        @(posedge CLK);
        rom_noise <= 1'b1;
        read_stream(ROM_ADDR_A, 40, 40);
        check_counter();

        // Restart mid-stream on another entry
        write_port(PORT_INDEX, 8'd5);
        write_port(PORT_OFFSET1, 8'hC3);
        read_stream(ROM_ADDR_B, 0, 30);
        @(posedge CLK);
        rom_noise <= 1'b0;
        check_counter();

        $display("Verification passed");
        $finish;
    end

endmodule
